// ==== side_ch_pkg.sv ====
// widths, sample and output word types, trigger select codes, sequencer states
package side_ch_pkg;

	localparam int iq_w   = 16;
	localparam int rssi_w = 11;  // signed, half-dB steps
	localparam int gpio_w = 8;   // [7] agc lock, [6:0] gain
	localparam int tsf_w  = 64;
	localparam int word_w = 64;

	typedef struct packed {
		logic signed [iq_w-1:0] i;
		logic signed [iq_w-1:0] q;
	} iq_pair_t;

	typedef logic [word_w-1:0] side_word_t;

	// stored sample, msb first
	typedef struct packed {
		logic [4:0]               zero_hi;
		logic signed [rssi_w-1:0] rssi;
		logic [7:0]               zero_lo;
		logic [gpio_w-1:0]        gpio;
		iq_pair_t                 iq;
	} sample_word_t;

	// agc_lock fires when lock is gained, agc_unlock when it is lost
	typedef enum logic [2:0] {
		rssi_rise  = 3'd0,
		rssi_fall  = 3'd1,
		agc_lock   = 3'd2,
		agc_unlock = 3'd3,
		gain_rise  = 3'd4,
		gain_fall  = 3'd5,
		tx_start   = 3'd6,
		tx_iq_over = 3'd7
	} trigger_sel_t;

	typedef enum logic [1:0] {
		idle   = 2'd0,
		fill   = 2'd1,  // post-trigger samples still going in
		header = 2'd2,  // timestamp word offered
		drain  = 2'd3   // window read-out
	} seq_state_t;

endpackage

// ==== capture_stream_if.sv ====
// valid/ready stream interface carrying capture words, with producer and consumer modports
`timescale 1ns/1ps

interface capture_stream_if;

	side_ch_pkg::side_word_t data;
	logic valid;
	logic ready;
	logic last;  // marks final word of a frame

	// word moves on a clock edge with valid and ready both high;
	// data, valid and last hold until then
	modport producer (
		output data,
		output valid,
		output last,
		input  ready
	);

	modport consumer (
		input  data,
		input  valid,
		input  last,
		output ready
	);

endinterface

// ==== trigger_detect.sv ====
// edge and threshold event detection on rssi, agc/gain and tx status, with trigger selection
`timescale 1ns/1ps

module trigger_detect (
	input  logic clk,
	input  logic rstn,
	input  logic capture_en,
	input  side_ch_pkg::trigger_sel_t trigger_select,
	input  logic signed [side_ch_pkg::rssi_w-1:0] rssi_half_db,
	input  logic signed [side_ch_pkg::rssi_w-1:0] rssi_th,
	input  logic [side_ch_pkg::gpio_w-1:0] gpio_status,
	input  logic [side_ch_pkg::gpio_w-2:0] gain_th,
	input  logic tx_bb_is_ongoing,
	input  side_ch_pkg::iq_pair_t iq,
	input  logic [side_ch_pkg::iq_w-1:0] iq_th,
	output logic trigger
);

	localparam int lock_bit = side_ch_pkg::gpio_w - 1;

	logic signed [side_ch_pkg::rssi_w-1:0] rssi_prev;
	logic [side_ch_pkg::gpio_w-1:0] gpio_prev;
	logic tx_prev;

	logic [side_ch_pkg::gpio_w-2:0] gain;
	logic [side_ch_pkg::gpio_w-2:0] gain_prev;
	logic [side_ch_pkg::iq_w-1:0] i_abs;
	logic [7:0] events;

	assign gain      = gpio_status[side_ch_pkg::gpio_w-2:0];
	assign gain_prev = gpio_prev[side_ch_pkg::gpio_w-2:0];

	// -32768 comes out as 16'h8000, still correct read unsigned
	assign i_abs = iq.i[side_ch_pkg::iq_w-1] ? side_ch_pkg::iq_w'(-iq.i) :
		side_ch_pkg::iq_w'(iq.i);

	// history of the status inputs
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_prev <= '0;
			gpio_prev <= '0;
			tx_prev   <= 1'b0;
		end else begin
			rssi_prev <= rssi_half_db;
			gpio_prev <= gpio_status;
			tx_prev   <= tx_bb_is_ongoing;
		end
	end

	// one bit per trigger_sel_t code
	always_comb begin
		events = '0;
		events[side_ch_pkg::rssi_rise] = (rssi_prev < rssi_th) && (rssi_half_db >= rssi_th);
		events[side_ch_pkg::rssi_fall] = (rssi_prev >= rssi_th) && (rssi_half_db < rssi_th);

		events[side_ch_pkg::agc_lock]   = !gpio_prev[lock_bit] && gpio_status[lock_bit];
		events[side_ch_pkg::agc_unlock] = gpio_prev[lock_bit] && !gpio_status[lock_bit];

		events[side_ch_pkg::gain_rise] = (gain_prev < gain_th) && (gain >= gain_th);
		events[side_ch_pkg::gain_fall] = (gain_prev >= gain_th) && (gain < gain_th);

		events[side_ch_pkg::tx_start]   = tx_bb_is_ongoing && !tx_prev;
		events[side_ch_pkg::tx_iq_over] = tx_prev && (i_abs > iq_th);  // self-interference check
	end

	// single cycle pulse, one edge after the causing input was sampled
	always_ff @(posedge clk) begin
		if (!rstn)
			trigger <= 1'b0;
		else
			trigger <= capture_en & events[trigger_select];
	end

endmodule

// ==== iq_ring_buffer.sv ====
// sample ring buffer with wrapping write pointer, freeze control and synchronous read
`timescale 1ns/1ps

module iq_ring_buffer #(
	parameter int addr_w = 9
) (
	input  logic clk,
	input  logic rstn,
	input  logic wr_en,
	input  side_ch_pkg::sample_word_t wr_data,
	input  logic [addr_w-1:0] rd_addr,
	input  logic wr_freeze,
	output logic [addr_w-1:0] wr_addr,
	output side_ch_pkg::sample_word_t rd_data
);

	side_ch_pkg::sample_word_t mem [0:2**addr_w-1];
	logic we;

	assign we = wr_en & !wr_freeze;

	// pointer wraps at 2**addr_w by overflow
	always_ff @(posedge clk) begin
		if (!rstn)
			wr_addr <= '0;
		else if (we)
			wr_addr <= wr_addr + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (we)
			mem[wr_addr] <= wr_data;
		// same address read sees the new sample
		if (we && (rd_addr == wr_addr))
			rd_data <= wr_data;
		else
			rd_data <= mem[rd_addr];
	end

endmodule

// ==== capture_sequencer.sv ====
// capture FSM: trigger accept, post-trigger fill, timestamp header and window read-out
`timescale 1ns/1ps

module capture_sequencer #(
	parameter int addr_w = 9
) (
	input  logic clk,
	input  logic rstn,
	input  logic capture_en,
	input  logic trigger,
	input  logic iq_strobe,
	input  logic [side_ch_pkg::tsf_w-1:0] tsf,
	input  logic [addr_w:0] pre_trigger_len,
	input  logic [addr_w:0] iq_len,
	input  logic [addr_w-1:0] wr_addr,
	input  side_ch_pkg::sample_word_t rd_data,
	output logic [addr_w-1:0] rd_addr,
	output logic wr_freeze,
	capture_stream_if.producer stream
);

	side_ch_pkg::seq_state_t state;

	logic [addr_w-1:0] rd_ptr;    // address of the word rd_data holds
	logic [addr_w:0] post_len;
	logic [addr_w:0] cnt;         // writes in fill, words sent in drain
	logic [addr_w:0] fill_cnt_next;
	logic wr_now;
	logic accept;
	logic fill_done;
	logic xfer;

	assign post_len = iq_len - pre_trigger_len;
	assign wr_now   = iq_strobe & capture_en;
	assign accept   = (state == side_ch_pkg::idle) & capture_en & trigger;
	assign xfer     = stream.valid & stream.ready;

	// anchor write at the accept edge counts as the first post sample
	assign fill_cnt_next = (state == side_ch_pkg::idle) ? (addr_w+1)'(wr_now) :
		cnt + (addr_w+1)'(wr_now);
	assign fill_done = (accept || (state == side_ch_pkg::fill)) && (fill_cnt_next == post_len);

	assign wr_freeze = (state == side_ch_pkg::header) || (state == side_ch_pkg::drain);

	// look-ahead address keeps rd_data equal to mem[rd_ptr] after every edge
	always_comb begin
		rd_addr = rd_ptr;
		if (accept)
			rd_addr = wr_addr - pre_trigger_len[addr_w-1:0];
		else if (xfer)
			rd_addr = rd_ptr + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state        <= side_ch_pkg::idle;
			stream.valid <= 1'b0;
			stream.last  <= 1'b0;
			rd_ptr       <= '0;
			cnt          <= '0;
		end else begin
			rd_ptr <= rd_addr;
			if (fill_done) begin
				state        <= side_ch_pkg::header;
				stream.valid <= 1'b1;  // header word offered
			end
			case (state)
				side_ch_pkg::idle: begin
					if (accept) begin
						cnt <= fill_cnt_next;
						if (!fill_done)
							state <= side_ch_pkg::fill;
					end
				end
				side_ch_pkg::fill: cnt <= fill_cnt_next;
				side_ch_pkg::header: begin
					if (xfer) begin
						state       <= side_ch_pkg::drain;
						cnt         <= (addr_w+1)'(1);
						stream.last <= (iq_len == (addr_w+1)'(1));
					end
				end
				side_ch_pkg::drain: begin
					if (xfer && stream.last) begin
						state        <= side_ch_pkg::idle;
						stream.valid <= 1'b0;
						stream.last  <= 1'b0;
					end else if (xfer) begin
						cnt         <= cnt + 1'b1;
						stream.last <= (cnt + 1'b1 == iq_len);
					end
				end
				default: state <= side_ch_pkg::idle;
			endcase
		end
	end

	// tsf latched straight into the header slot, samples follow on each transfer
	always_ff @(posedge clk) begin
		if (accept)
			stream.data <= side_ch_pkg::side_word_t'(tsf);
		else if (xfer)
			stream.data <= side_ch_pkg::side_word_t'(rd_data);
	end

endmodule

// ==== stream_skid_buffer.sv ====
// two-entry registered output stage for the capture stream, absorbs ready stalls
`timescale 1ns/1ps

module stream_skid_buffer (
	input  logic clk,
	input  logic rstn,
	capture_stream_if.consumer s,
	output side_ch_pkg::side_word_t m_data,
	output logic m_valid,
	output logic m_last,
	input  logic m_ready
);

	side_ch_pkg::side_word_t skid_data;
	logic skid_last;
	logic skid_valid;
	logic in_xfer;
	logic out_free;

	assign s.ready  = !skid_valid;  // low only with both entries full
	assign in_xfer  = s.valid & s.ready;
	assign out_free = !m_valid | m_ready;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			m_valid    <= 1'b0;
			m_last     <= 1'b0;
			skid_valid <= 1'b0;
		end else if (out_free) begin
			m_valid    <= skid_valid | in_xfer;
			m_last     <= skid_valid ? skid_last : (in_xfer & s.last);
			skid_valid <= 1'b0;
		end else if (in_xfer) begin
			skid_valid <= 1'b1;  // output stalled, park it
		end
	end

	always_ff @(posedge clk) begin
		if (out_free) begin
			if (skid_valid)
				m_data <= skid_data;
			else if (in_xfer)
				m_data <= s.data;
		end else if (in_xfer) begin
			skid_data <= s.data;
			skid_last <= s.last;
		end
	end

endmodule

// ==== side_ch_iq_capture.sv ====
// top level of the side channel i/q capture: sample packing, trigger, buffer, sequencer, output
`timescale 1ns/1ps

module side_ch_iq_capture #(
	parameter int addr_w = 9
) (
	input  logic clk,
	input  logic rstn,
	input  logic capture_en,
	input  side_ch_pkg::trigger_sel_t trigger_select,
	input  side_ch_pkg::iq_pair_t iq,
	input  logic iq_strobe,
	input  logic signed [side_ch_pkg::rssi_w-1:0] rssi_half_db,
	input  logic [side_ch_pkg::gpio_w-1:0] gpio_status,
	input  logic tx_bb_is_ongoing,
	input  logic [side_ch_pkg::tsf_w-1:0] tsf,
	input  logic signed [side_ch_pkg::rssi_w-1:0] rssi_th,
	input  logic [side_ch_pkg::iq_w-1:0] iq_th,
	input  logic [side_ch_pkg::gpio_w-2:0] gain_th,
	input  logic [addr_w:0] pre_trigger_len,
	input  logic [addr_w:0] iq_len,
	input  logic out_ready,
	output side_ch_pkg::side_word_t out_data,
	output logic out_valid,
	output logic out_last
);

	side_ch_pkg::sample_word_t wr_data;
	side_ch_pkg::sample_word_t rd_data;
	logic [addr_w-1:0] wr_addr;
	logic [addr_w-1:0] rd_addr;
	logic wr_en;
	logic wr_freeze;
	logic trigger;

	capture_stream_if stream_i ();

	assign wr_data = '{zero_hi: '0, rssi: rssi_half_db, zero_lo: '0,
		gpio: gpio_status, iq: iq};
	assign wr_en = iq_strobe & capture_en;

	trigger_detect trigger_detect_i (
		.clk(clk), .rstn(rstn), .capture_en(capture_en),
		.trigger_select(trigger_select),
		.rssi_half_db(rssi_half_db), .rssi_th(rssi_th),
		.gpio_status(gpio_status), .gain_th(gain_th),
		.tx_bb_is_ongoing(tx_bb_is_ongoing), .iq(iq), .iq_th(iq_th),
		.trigger(trigger)
	);

	iq_ring_buffer #(.addr_w(addr_w)) iq_ring_buffer_i (
		.clk(clk), .rstn(rstn), .wr_en(wr_en), .wr_data(wr_data),
		.rd_addr(rd_addr), .wr_freeze(wr_freeze),
		.wr_addr(wr_addr), .rd_data(rd_data)
	);

	capture_sequencer #(.addr_w(addr_w)) capture_sequencer_i (
		.clk(clk), .rstn(rstn), .capture_en(capture_en), .trigger(trigger),
		.iq_strobe(iq_strobe), .tsf(tsf),
		.pre_trigger_len(pre_trigger_len), .iq_len(iq_len),
		.wr_addr(wr_addr), .rd_data(rd_data),
		.rd_addr(rd_addr), .wr_freeze(wr_freeze),
		.stream(stream_i.producer)
	);

	// registered output, also cuts out_ready off from the FSM
	stream_skid_buffer stream_skid_buffer_i (
		.clk(clk), .rstn(rstn), .s(stream_i.consumer),
		.m_data(out_data), .m_valid(out_valid), .m_last(out_last),
		.m_ready(out_ready)
	);

endmodule

// ==== tb_side_ch_checker.sv ====
// output protocol and reset assertions for the capture top level, with its bind
`timescale 1ns/1ps

module tb_side_ch_checker (
	input logic clk,
	input logic rstn,
	input logic trigger,
	input side_ch_pkg::side_word_t out_data,
	input logic out_valid,
	input logic out_ready,
	input logic out_last
);

	int fails = 0;  // read by the testbench at the end

	// a stalled word holds until it is taken
	stall_hold: assert property (@(posedge clk) disable iff (!rstn)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
	else begin
		fails++;
		$error("out_valid dropped or output word changed while out_ready was low");
	end

	last_with_valid: assert property (@(posedge clk) disable iff (!rstn)
		out_last |-> out_valid)
	else begin
		fails++;
		$error("out_last high without out_valid");
	end

	reset_quiet: assert property (@(posedge clk) !rstn |=> !out_valid && !out_last && !trigger)
	else begin
		fails++;
		$error("output or trigger active right after a reset cycle");
	end

endmodule

bind side_ch_iq_capture tb_side_ch_checker protocol_chk (
	.clk(clk), .rstn(rstn), .trigger(trigger), .out_data(out_data),
	.out_valid(out_valid), .out_ready(out_ready), .out_last(out_last)
);

// ==== tb_side_ch.sv ====
// testbench for the i/q capture top: stimulus table, frame scoreboard, watchdog, report
`timescale 1ns/1ps

module tb_side_ch;

	localparam int addr_w = 9;
	localparam int n_rows = 13;
	localparam int hist_n = 2048;  // sample history, well beyond one window
	localparam logic [63:0] tsf_base = 64'h0123_4567_0000_0000;
	localparam logic signed [side_ch_pkg::rssi_w-1:0] rssi_lo = -11'sd180;
	localparam logic signed [side_ch_pkg::rssi_w-1:0] rssi_hi = -11'sd90;
	localparam logic [6:0] gain_lo = 7'd20;
	localparam logic [6:0] gain_hi = 7'd60;
	localparam logic signed [15:0] neg_i_val = -16'sd6000;  // beyond iq_th of 5000
	localparam int ev_rssi_up = 0;
	localparam int ev_rssi_down = 1;
	localparam int ev_lock = 2;
	localparam int ev_unlock = 3;
	localparam int ev_gain_up = 4;
	localparam int ev_gain_down = 5;
	localparam int ev_tx_on = 6;
	localparam int ev_iq_neg = 7;
	localparam int ev_tx_off = 8;

	typedef struct {
		side_ch_pkg::trigger_sel_t sel;
		int kind;
		int lead;   // quiet cycles before the event
		int pre;
		int len;
		bit frame;  // frame expected
		bit rnd;    // random out_ready
		bit en;     // capture_en for the row
		int again;  // cycles to a repeated event, 0 for none
	} row_t;

	logic clk;
	logic rstn;
	logic capture_en;
	side_ch_pkg::trigger_sel_t trigger_select;
	side_ch_pkg::iq_pair_t iq;
	logic iq_strobe;
	logic signed [side_ch_pkg::rssi_w-1:0] rssi_half_db;
	logic signed [side_ch_pkg::rssi_w-1:0] rssi_th;
	logic [side_ch_pkg::gpio_w-1:0] gpio_status;
	logic tx_bb_is_ongoing;
	logic [side_ch_pkg::tsf_w-1:0] tsf;
	logic [side_ch_pkg::iq_w-1:0] iq_th;
	logic [side_ch_pkg::gpio_w-2:0] gain_th;
	logic [addr_w:0] pre_trigger_len;
	logic [addr_w:0] iq_len;
	logic out_ready;
	side_ch_pkg::side_word_t out_data;
	logic out_valid;
	logic out_last;

	row_t rows [n_rows];
	logic [63:0] hist [0:hist_n-1];  // expected word per sample index
	side_ch_pkg::side_word_t got_data [$];
	bit got_last [$];
	bit frame_done;
	bit valid_seen;
	int cyc;
	int errors;
	int checks;
	logic [31:0] lfsr = 32'h53859b27;
	side_ch_pkg::trigger_sel_t sel_lvl;
	logic signed [side_ch_pkg::rssi_w-1:0] rssi_lvl;
	logic [6:0] gain_lvl;
	logic lock_lvl;
	logic tx_lvl;
	logic neg_i;
	logic en_lvl;
	logic rnd_ready;
	int pre_lvl;
	int len_lvl;

	side_ch_iq_capture #(.addr_w(addr_w)) side_ch_iq_capture_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// one clock: next sample, tsf and the current levels, all on the rising edge
	task automatic step();
		logic [15:0] i_val;
		logic [15:0] q_val;
		@(posedge clk);
		cyc++;
		i_val = neg_i ? neg_i_val : {4'h0, cyc[11:0]};
		q_val = cyc[15:0];
		iq <= {i_val, q_val};
		tsf <= tsf_base + 64'(cyc);
		rssi_half_db <= rssi_lvl;
		gpio_status <= {lock_lvl, gain_lvl};
		tx_bb_is_ongoing <= tx_lvl;
		capture_en <= en_lvl;
		trigger_select <= sel_lvl;
		pre_trigger_len <= (addr_w+1)'(pre_lvl);
		iq_len <= (addr_w+1)'(len_lvl);
		out_ready <= rnd_ready ? next_random_bit() : 1'b1;
		hist[cyc % hist_n] = {5'b0, rssi_lvl, 8'b0, lock_lvl, gain_lvl, i_val, q_val};
	endtask

	task automatic apply_event(input int kind, input bit undo);
		case (kind)
			ev_rssi_up:   rssi_lvl = undo ? rssi_lo : rssi_hi;
			ev_rssi_down: rssi_lvl = undo ? rssi_hi : rssi_lo;
			ev_lock:      lock_lvl = !undo;
			ev_unlock:    lock_lvl = undo;
			ev_gain_up:   gain_lvl = undo ? gain_lo : gain_hi;
			ev_gain_down: gain_lvl = undo ? gain_hi : gain_lo;
			ev_tx_on:     tx_lvl = !undo;
			ev_iq_neg:    neg_i = !undo;
			default:      tx_lvl = undo;  // tx off
		endcase
	endtask

	task automatic load_rows();
		rows[0]  = '{side_ch_pkg::rssi_rise,  ev_rssi_up,    12,   4,  16, 0, 0, 0,  0};
		rows[1]  = '{side_ch_pkg::rssi_fall,  ev_rssi_down,  12,   4,  16, 1, 0, 1,  0};
		rows[2]  = '{side_ch_pkg::rssi_rise,  ev_rssi_up,    16,   8,  32, 1, 1, 1,  3};
		rows[3]  = '{side_ch_pkg::agc_lock,   ev_gain_up,    10,   2,   8, 0, 0, 1,  0};
		rows[4]  = '{side_ch_pkg::agc_lock,   ev_lock,        6,   0,   8, 1, 1, 1,  0};
		rows[5]  = '{side_ch_pkg::agc_unlock, ev_unlock,     12,   7,   8, 1, 0, 1,  0};
		rows[6]  = '{side_ch_pkg::gain_fall,  ev_gain_down,  24,  16,  48, 1, 1, 1, 40};
		rows[7]  = '{side_ch_pkg::gain_rise,  ev_gain_up,   110, 100, 512, 1, 0, 1,  0};
		rows[8]  = '{side_ch_pkg::tx_iq_over, ev_iq_neg,     10,   2,   8, 0, 0, 1,  0};
		rows[9]  = '{side_ch_pkg::tx_start,   ev_tx_on,      10,   5,  20, 1, 1, 1,  0};
		rows[10] = '{side_ch_pkg::tx_iq_over, ev_iq_neg,     10,   3,  12, 1, 1, 1,  0};
		rows[11] = '{side_ch_pkg::rssi_fall,  ev_tx_off,     10,   2,   8, 0, 0, 1,  0};
		rows[12] = '{side_ch_pkg::rssi_fall,  ev_rssi_down,  10,   1,   2, 1, 1, 1,  0};
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %0t ns %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// header is tsf at the accept edge, then samples from anchor - pre on
	task automatic check_frame(input int anchor, input int pre, input int len);
		int first;
		first = anchor - pre;
		checks++;
		assert (frame_done && got_data.size() == len + 1) else begin
			errors++;
			$display("frame incomplete or of wrong length: %0d words seen, %0d expected",
				got_data.size(), len + 1);
		end
		if (got_data.size() >= len + 1) begin
			check_value("out_data[header]", got_data[0], tsf_base + 64'(anchor));
			for (int k = 0; k < len; k++)
				check_value($sformatf("out_data[%0d]", k + 1), got_data[k + 1],
					hist[(first + k) % hist_n]);
			for (int k = 0; k <= len; k++)
				check_value($sformatf("out_last[%0d]", k), 64'(got_last[k]), 64'(k == len));
		end
	endtask

	task automatic run_row(input row_t r);
		int anchor;
		int waited;
		sel_lvl = r.sel;
		pre_lvl = r.pre;
		len_lvl = r.len;
		en_lvl = r.en;
		rnd_ready = r.rnd;
		got_data.delete();
		got_last.delete();
		frame_done = 1'b0;
		valid_seen = 1'b0;
		repeat (r.lead) step();
		apply_event(r.kind, 1'b0);
		step();
		anchor = cyc + 1;  // sample written at the accept edge
		neg_i = 1'b0;
		if (r.again > 0) begin
			repeat (r.again) step();
			apply_event(r.kind, 1'b1);
			step();
			apply_event(r.kind, 1'b0);  // same event while busy
			step();
			neg_i = 1'b0;
		end
		waited = 0;
		if (r.frame) begin
			while (!frame_done && waited < r.len * 4 + 40) begin
				step();
				waited++;
			end
			check_frame(anchor, r.pre, r.len);
		end else begin
			repeat (r.len * 2 + 20) step();
			checks++;
			assert (!valid_seen) else begin
				errors++;
				$display("output became valid although no trigger should be accepted");
			end
		end
		valid_seen = 1'b0;
		repeat (8) step();
		checks++;
		assert (!valid_seen) else begin
			errors++;
			$display("output became valid again after the frame ended");
		end
	endtask

	// transfers happen on the next rising edge, so sample halfway
	always @(negedge clk) begin
		if (rstn && out_valid)
			valid_seen = 1'b1;
		if (rstn && out_valid && out_ready) begin
			got_data.push_back(out_data);
			got_last.push_back(out_last);
			if (out_last)
				frame_done = 1'b1;
		end
	end

	initial begin
		longint limit;
		#1;
		limit = 0;
		for (int n = 0; n < n_rows; n++)
			limit += rows[n].lead + rows[n].len * 4 + 50;
		#(limit * 40);
		$display("watchdog expired after %0d ns, run did not complete", limit * 40);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		int err0;
		rstn = 1'b0;
		capture_en = 1'b0;
		trigger_select = side_ch_pkg::rssi_rise;
		iq = '0;
		iq_strobe = 1'b1;
		rssi_half_db = rssi_lo;
		rssi_th = -11'sd120;
		gpio_status = '0;
		tx_bb_is_ongoing = 1'b0;
		tsf = '0;
		iq_th = 16'd5000;
		gain_th = 7'd40;
		pre_trigger_len = '0;
		iq_len = (addr_w+1)'(1);
		out_ready = 1'b1;
		sel_lvl = side_ch_pkg::rssi_rise;
		rssi_lvl = rssi_lo;
		gain_lvl = gain_lo;
		lock_lvl = 1'b0;
		tx_lvl = 1'b0;
		neg_i = 1'b0;
		en_lvl = 1'b0;
		rnd_ready = 1'b0;
		pre_lvl = 0;
		len_lvl = 1;
		cyc = 0;
		errors = 0;
		checks = 0;
		load_rows();
		repeat (8) step();
		rstn <= 1'b1;
		for (int n = 0; n < n_rows; n++) begin
			err0 = errors;
			run_row(rows[n]);
			$display("row %0d %s, frame expected %0d: %s", n, rows[n].sel.name(),
				rows[n].frame, (errors == err0) ? "ok" : "mismatch");
		end
		$display("%0d rows, %0d checks, %0d errors, %0d assertion failures", n_rows, checks,
			errors, side_ch_iq_capture_i.protocol_chk.fails);
		if (errors == 0 && side_ch_iq_capture_i.protocol_chk.fails == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
side_ch_pkg.sv
capture_stream_if.sv
trigger_detect.sv
iq_ring_buffer.sv
capture_sequencer.sv
stream_skid_buffer.sv
side_ch_iq_capture.sv
tb_side_ch_checker.sv
tb_side_ch.sv

// ==== Bender.yml ====
package:
  name: side_ch_iq_capture

sources:
  - side_ch_pkg.sv
  - capture_stream_if.sv
  - trigger_detect.sv
  - iq_ring_buffer.sv
  - capture_sequencer.sv
  - stream_skid_buffer.sv
  - side_ch_iq_capture.sv
  - target: test
    files:
      - tb_side_ch_checker.sv
      - tb_side_ch.sv
